// ==== compile.f ====
+incdir+src
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_fetch_decode.sv
src/rv_execute.sv
src/rv_mem_wb.sv
src/rv_core.sv
bench/rv_core_checker.sv
bench/rv_core_tb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module rv_core_tb \
    -Mdir obj_dir -o rv_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_core_tb;

    localparam int MAX_DELAY   = 3;
    localparam int TOTAL_INSNS = 80;
    // a memory op can wait on AW/W, B, then AR or R, each up to MAX_DELAY
    localparam int INSN_CYCLES = 3 + 3 * (MAX_DELAY + 1);
    localparam int RESET_BUDGET = 6 * 14;
    localparam realtime WATCHDOG_NS = 2 * (TOTAL_INSNS * INSN_CYCLES + RESET_BUDGET) * 8.0;

    typedef struct packed {
        rv_pkg::word_t         addr;
        rv_pkg::word_t         data;
        logic [`RV_XLEN/8-1:0] strb;
    } store_rec_t;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    rv_pkg::word_t     imem_addr;
    rv_pkg::word_t     imem_data;
    rv_pkg::axil_req_t bus_req;
    rv_pkg::axil_rsp_t bus_rsp = '0;

    rv_pkg::word_t rom [0:63] = '{default: '0};
    int            rom_len;
    rv_pkg::word_t halt_pc;
    rv_pkg::word_t dmem [int];
    store_rec_t    stores [$];
    rv_pkg::word_t fetches [$];
    logic          bus_seen;
    logic [31:0]   lfsr_state = 32'd72912;
    int            errors;
    int            tests_run;
    int            tests_failed;

    // bus model state
    rv_pkg::axil_req_t     req_q;
    logic                  rst_at_edge;
    logic                  aw_got, w_got, ar_got;
    int                    aw_wait, w_wait, b_wait, ar_wait, r_wait;
    rv_pkg::word_t         aw_addr, w_data, ar_addr;
    logic [`RV_XLEN/8-1:0] w_strb;

    rv_core UUT (
        .clk(clk),
        .rst(rst),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp)
    );

    always #4 clk = ~clk;

    assign imem_data = rom[imem_addr[7:2]];

    // taps 32,22,2,1
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int ready_delay();
        return int'(random_bits(2));
    endfunction

    function automatic rv_pkg::word_t read_word(rv_pkg::word_t addr);
        if (dmem.exists(int'(addr[31:2]))) begin
            return dmem[int'(addr[31:2])];
        end
        return ~addr ^ 32'h5a5a_5a5a;
    endfunction

    always @(posedge clk) begin
        rst_at_edge = rst;
        #1;
        if (rst_at_edge) begin
            bus_rsp  = '0;
            req_q    = '0;
            aw_got   = 1'b0;
            w_got    = 1'b0;
            ar_got   = 1'b0;
            aw_wait  = ready_delay();
            w_wait   = ready_delay();
            b_wait   = ready_delay();
            ar_wait  = ready_delay();
            r_wait   = ready_delay();
            bus_seen = 1'b0;
        end else begin
            // handshakes taken at the edge just passed
            if (req_q.awvalid && bus_rsp.awready) begin
                aw_got          = 1'b1;
                aw_addr         = req_q.awaddr;
                bus_rsp.awready = 1'b0;
                aw_wait         = ready_delay();
            end
            if (req_q.wvalid && bus_rsp.wready) begin
                w_got          = 1'b1;
                w_data         = req_q.wdata;
                w_strb         = req_q.wstrb;
                bus_rsp.wready = 1'b0;
                w_wait         = ready_delay();
            end
            if (req_q.bready && bus_rsp.bvalid) begin
                bus_rsp.bvalid = 1'b0;
                aw_got         = 1'b0;
                w_got          = 1'b0;
                b_wait         = ready_delay();
            end
            if (req_q.arvalid && bus_rsp.arready) begin
                ar_got          = 1'b1;
                ar_addr         = req_q.araddr;
                bus_rsp.arready = 1'b0;
                ar_wait         = ready_delay();
            end
            if (req_q.rready && bus_rsp.rvalid) begin
                bus_rsp.rvalid = 1'b0;
                ar_got         = 1'b0;
                r_wait         = ready_delay();
            end

            if (bus_req.awvalid && !aw_got && !bus_rsp.awready) begin
                if (aw_wait == 0) bus_rsp.awready = 1'b1;
                else aw_wait--;
            end
            if (bus_req.wvalid && !w_got && !bus_rsp.wready) begin
                if (w_wait == 0) bus_rsp.wready = 1'b1;
                else w_wait--;
            end
            if (aw_got && w_got && !bus_rsp.bvalid) begin
                if (b_wait == 0) begin
                    dmem[int'(aw_addr[31:2])] = w_data;
                    stores.push_back('{addr: aw_addr, data: w_data, strb: w_strb});
                    bus_rsp.bvalid = 1'b1;
                    bus_rsp.bresp  = 2'b00;
                end else begin
                    b_wait--;
                end
            end
            if (bus_req.arvalid && !ar_got && !bus_rsp.arready) begin
                if (ar_wait == 0) bus_rsp.arready = 1'b1;
                else ar_wait--;
            end
            if (ar_got && !bus_rsp.rvalid) begin
                if (r_wait == 0) begin
                    bus_rsp.rvalid = 1'b1;
                    bus_rsp.rdata  = read_word(ar_addr);
                    bus_rsp.rresp  = 2'b00;
                end else begin
                    r_wait--;
                end
            end

            if (bus_req.awvalid || bus_req.wvalid || bus_req.arvalid) bus_seen = 1'b1;
            if (fetches.size() == 0 || imem_addr != fetches[$]) fetches.push_back(imem_addr);
            req_q = bus_req;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not reach their halt loops in time");
        $display("Regression failed");
        $finish;
    end

    function automatic rv_pkg::word_t r_type(logic [6:0] f7, int rs2, int rs1,
                                             logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::OP};
    endfunction

    function automatic rv_pkg::word_t i_type(int imm, int rs1, logic [2:0] f3, int rd,
                                             rv_pkg::opcode_t op);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic rv_pkg::word_t s_type(int imm, int rs2, int rs1);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], rv_pkg::STORE};
    endfunction

    function automatic rv_pkg::word_t u_type(logic [19:0] upper, int rd);
        return {upper, 5'(rd), rv_pkg::LUI};
    endfunction

    function automatic rv_pkg::word_t j_type(int off, int rd);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), rv_pkg::JAL};
    endfunction

    task automatic emit(rv_pkg::word_t insn);
        rom[rom_len] = insn;
        rom_len++;
    endtask

    task automatic emit_halt();
        halt_pc = rv_pkg::word_t'(rom_len * 4);
        emit(j_type(0, 0));
    endtask

    // lui + addi, upper part rounded for the sign of the low 12 bits
    task automatic load_const(int rd, rv_pkg::word_t w);
        rv_pkg::word_t upper;
        upper = (w + 32'h800) >> 12;
        emit(u_type(upper[19:0], rd));
        emit(i_type(int'(w[11:0]), rd, 3'b000, rd, rv_pkg::OP_IMM));
    endtask

    task automatic reset_core();
        @(posedge clk);
        #1 rst = 1'b1;
        // bus model is held in reset from the next edge on
        @(posedge clk);
        #2;
        for (int i = 0; i < 64; i++) rom[i] = '0;
        rom_len = 0;
        dmem.delete();
        stores.delete();
        fetches.delete();
        repeat (9) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic run_until(rv_pkg::word_t pc);
        do begin
            @(posedge clk);
            #2;
        end while (imem_addr != pc);
    endtask

    task automatic run_program();
        run_until(halt_pc);
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic check_word(string what, rv_pkg::word_t got, rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_store(int idx, rv_pkg::word_t addr, rv_pkg::word_t data);
        if (idx >= stores.size()) begin
            $display("store number %0d never appeared on the bus", idx);
            errors++;
        end else if (stores[idx].addr !== addr || stores[idx].data !== data ||
                     stores[idx].strb !== '1) begin
            $display("ERROR at %0t: store %0d wrote %h to %h with strobes %b, expected %h to %h",
                     $time, idx, stores[idx].data, stores[idx].addr, stores[idx].strb,
                     data, addr);
            errors++;
        end
    endtask

    task automatic check_fetch(int idx, rv_pkg::word_t addr);
        if (idx >= fetches.size()) begin
            $display("fetch number %0d never happened", idx);
            errors++;
        end else begin
            check_word($sformatf("fetch %0d address", idx), fetches[idx], addr);
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED", name);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        reset_core();
        emit(i_type(5, 0, 3'b000, 1, rv_pkg::OP_IMM));
        emit(i_type(9, 0, 3'b000, 2, rv_pkg::OP_IMM));
        emit(s_type(0, 1, 0));
        emit_halt();
        run_until(32'h8);
        if (bus_seen) begin
            $display("a bus valid went high before the first store");
            errors++;
        end
        run_program();
        check_fetch(0, `RV_RESET_PC);
        check_store(0, 32'h0, 32'd5);
        report_test("reset", e);
    endtask

    task automatic test_reg_alu();
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t exp [7];
        int e;
        e = errors;
        a = rv_pkg::word_t'(-7);
        b = 32'd12;
        exp = '{a + b, a - b, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0,
                ($signed(b) < $signed(a)) ? 32'd1 : 32'd0, a ^ b, a | b, a & b};
        reset_core();
        emit(i_type(-7, 0, 3'b000, 1, rv_pkg::OP_IMM));
        emit(i_type(12, 0, 3'b000, 2, rv_pkg::OP_IMM));
        emit(r_type(7'h00, 2, 1, 3'b000, 3));
        emit(s_type(0, 3, 0));
        emit(r_type(7'h20, 2, 1, 3'b000, 3));
        emit(s_type(4, 3, 0));
        emit(r_type(7'h00, 2, 1, 3'b010, 3));
        emit(s_type(8, 3, 0));
        emit(r_type(7'h00, 1, 2, 3'b010, 3));
        emit(s_type(12, 3, 0));
        emit(r_type(7'h00, 2, 1, 3'b100, 3));
        emit(s_type(16, 3, 0));
        emit(r_type(7'h00, 2, 1, 3'b110, 3));
        emit(s_type(20, 3, 0));
        emit(r_type(7'h00, 2, 1, 3'b111, 3));
        emit(s_type(24, 3, 0));
        emit_halt();
        run_program();
        for (int i = 0; i < 7; i++) check_store(i, rv_pkg::word_t'(i * 4), exp[i]);
        report_test("register alu", e);
    endtask

    task automatic test_imm_alu();
        rv_pkg::word_t a;
        rv_pkg::word_t exp [7];
        int e;
        e = errors;
        a = rv_pkg::word_t'(-1234);
        exp = '{a ^ 32'h5a5, a | 32'h0f0, a & 32'hffff_ff00, a << 4, a >> 8,
                rv_pkg::word_t'($signed(a) >>> 8), 32'habcd_e000};
        reset_core();
        emit(i_type(-1234, 0, 3'b000, 1, rv_pkg::OP_IMM));
        emit(i_type(12'h5a5, 1, 3'b100, 3, rv_pkg::OP_IMM));
        emit(s_type(0, 3, 0));
        emit(i_type(12'h0f0, 1, 3'b110, 3, rv_pkg::OP_IMM));
        emit(s_type(4, 3, 0));
        emit(i_type(-256, 1, 3'b111, 3, rv_pkg::OP_IMM));
        emit(s_type(8, 3, 0));
        emit(i_type(4, 1, 3'b001, 3, rv_pkg::OP_IMM));
        emit(s_type(12, 3, 0));
        emit(i_type(8, 1, 3'b101, 3, rv_pkg::OP_IMM));
        emit(s_type(16, 3, 0));
        emit(i_type(12'h408, 1, 3'b101, 3, rv_pkg::OP_IMM));
        emit(s_type(20, 3, 0));
        emit(u_type(20'habcde, 3));
        emit(s_type(24, 3, 0));
        emit_halt();
        run_program();
        for (int i = 0; i < 7; i++) check_store(i, rv_pkg::word_t'(i * 4), exp[i]);
        report_test("immediate alu", e);
    endtask

    task automatic test_load_store();
        rv_pkg::word_t w [4];
        int e;
        e = errors;
        for (int k = 0; k < 4; k++) w[k] = random_bits(32);
        reset_core();
        for (int k = 0; k < 4; k++) begin
            load_const(k + 1, w[k]);
            emit(s_type(12'h100 + 4 * k, k + 1, 0));
        end
        for (int k = 0; k < 4; k++) begin
            emit(i_type(12'h100 + 4 * k, 0, 3'b010, k + 10, rv_pkg::LOAD));
            emit(s_type(12'h200 + 4 * k, k + 10, 0));
        end
        emit_halt();
        run_program();
        for (int k = 0; k < 4; k++) begin
            check_store(k, rv_pkg::word_t'(32'h100 + 4 * k), w[k]);
            check_store(k + 4, rv_pkg::word_t'(32'h200 + 4 * k), w[k]);
        end
        report_test("load and store", e);
    endtask

    task automatic test_jumps();
        rv_pkg::word_t path [7];
        int e;
        e = errors;
        path = '{32'd0, 32'd12, 32'd16, 32'd20, 32'd36, 32'd40, 32'd44};
        reset_core();
        emit(j_type(12, 1));
        emit(i_type(1, 0, 3'b000, 5, rv_pkg::OP_IMM));
        emit(i_type(2, 0, 3'b000, 5, rv_pkg::OP_IMM));
        emit(s_type(12'h40, 1, 0));
        // odd target, low bit must be dropped
        emit(i_type(37, 0, 3'b000, 2, rv_pkg::OP_IMM));
        emit(i_type(0, 2, 3'b000, 3, rv_pkg::JALR));
        for (int i = 0; i < 3; i++) emit(i_type(3, 0, 3'b000, 5, rv_pkg::OP_IMM));
        emit(s_type(12'h44, 3, 0));
        emit(s_type(12'h48, 5, 0));
        emit_halt();
        run_program();
        check_store(0, 32'h40, 32'd4);
        check_store(1, 32'h44, 32'd24);
        check_store(2, 32'h48, 32'd0);
        for (int i = 0; i < 7; i++) check_fetch(i, path[i]);
        report_test("jumps", e);
    endtask

    task automatic test_x0();
        int e;
        e = errors;
        reset_core();
        emit(i_type(55, 0, 3'b000, 0, rv_pkg::OP_IMM));
        emit(u_type(20'h12345, 0));
        emit(s_type(12'h80, 0, 0));
        // unwritten word, reads back the nonzero fill
        emit(i_type(12'h88, 0, 3'b010, 0, rv_pkg::LOAD));
        emit(s_type(12'h84, 0, 0));
        emit_halt();
        run_program();
        check_store(0, 32'h80, 32'h0);
        check_store(1, 32'h84, 32'h0);
        report_test("x0", e);
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_reset();
        test_reg_alu();
        test_imm_alu();
        test_load_store();
        test_jumps();
        test_x0();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== bench/rv_core_checker.sv ====
`timescale 1ns/100ps

module rv_core_checker (
    input logic              clk,
    input logic              rst,
    input rv_pkg::word_t     imem_addr,
    input rv_pkg::axil_req_t bus_req,
    input rv_pkg::axil_rsp_t bus_rsp
);

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        bus_req.awvalid && !bus_rsp.awready |=> bus_req.awvalid && $stable(bus_req.awaddr))
        else $error("awvalid or awaddr changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        bus_req.wvalid && !bus_rsp.wready |=> bus_req.wvalid && $stable(bus_req.wdata))
        else $error("wvalid or wdata changed before wready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        bus_req.arvalid && !bus_rsp.arready |=> bus_req.arvalid && $stable(bus_req.araddr))
        else $error("arvalid or araddr changed before arready");

    // one transfer at a time
    no_overlap: assert property (@(posedge clk) disable iff (rst)
        !((bus_req.awvalid || bus_req.wvalid || bus_req.bready) &&
          (bus_req.arvalid || bus_req.rready)))
        else $error("read and write outstanding together");

    fetch_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

endmodule

bind rv_core rv_core_checker checker_inst (
    .clk(clk),
    .rst(rst),
    .imem_addr(imem_addr),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp)
);

// ==== src/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
    input  logic              clk,
    input  logic              rst,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::axil_req_t bus_req,
    input  rv_pkg::axil_rsp_t bus_rsp
);

    rv_pkg::reg_addr_t    rs1_addr;
    rv_pkg::reg_addr_t    rs2_addr;
    rv_pkg::word_t        rs1_value;
    rv_pkg::word_t        rs2_value;
    rv_pkg::decoded_t     decoded;
    logic                 decoded_valid;
    rv_pkg::exec_result_t result;
    logic                 result_valid;
    rv_pkg::retire_t      retire;

    rv_regfile regfile (
        .clk(clk),
        .rst(rst),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .retire(retire)
    );

    rv_fetch_decode fetch_decode (
        .clk(clk),
        .rst(rst),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .retire(retire),
        .decoded(decoded),
        .decoded_valid(decoded_valid)
    );

    rv_execute execute (
        .clk(clk),
        .rst(rst),
        .decoded(decoded),
        .decoded_valid(decoded_valid),
        .result(result),
        .result_valid(result_valid)
    );

    rv_mem_wb mem_wb (
        .clk(clk),
        .rst(rst),
        .result(result),
        .result_valid(result_valid),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp),
        .retire(retire)
    );

endmodule

// ==== src/rv_mem_wb.sv ====
`timescale 1ns/100ps

module rv_mem_wb (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_pkg::exec_result_t result,
    input  logic                 result_valid,
    output rv_pkg::axil_req_t    bus_req,
    input  rv_pkg::axil_rsp_t    bus_rsp,
    output rv_pkg::retire_t      retire
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITE_ADDR_DATA,
        S_WRITE_RESP,
        S_READ_ADDR,
        S_READ_DATA
    } state_t;

    state_t state;
    logic   aw_done;
    logic   w_done;
    logic   aw_hs;
    logic   w_hs;

    // result register in execute holds still until the next retire
    always_comb begin
        bus_req         = '0;
        bus_req.awaddr  = result.alu_result;
        bus_req.araddr  = result.alu_result;
        bus_req.wdata   = result.store_data;
        bus_req.wstrb   = '1;
        bus_req.awvalid = (state == S_WRITE_ADDR_DATA) && !aw_done;
        bus_req.wvalid  = (state == S_WRITE_ADDR_DATA) && !w_done;
        bus_req.bready  = (state == S_WRITE_RESP);
        bus_req.arvalid = (state == S_READ_ADDR);
        bus_req.rready  = (state == S_READ_DATA);
    end

    assign aw_hs = bus_req.awvalid && bus_rsp.awready;
    assign w_hs  = bus_req.wvalid && bus_rsp.wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (result_valid && result.is_store) begin
                        state <= S_WRITE_ADDR_DATA;
                    end else if (result_valid && result.is_load) begin
                        state <= S_READ_ADDR;
                    end
                end
                S_WRITE_ADDR_DATA: begin
                    aw_done <= aw_done | aw_hs;
                    w_done  <= w_done | w_hs;
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        state <= S_WRITE_RESP;
                    end
                end
                S_WRITE_RESP: begin
                    if (bus_rsp.bvalid) begin
                        state <= S_IDLE;
                    end
                end
                S_READ_ADDR: begin
                    if (bus_rsp.arready) begin
                        state <= S_READ_DATA;
                    end
                end
                S_READ_DATA: begin
                    if (bus_rsp.rvalid) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // retire on the response handshake, or straight away without memory
    always_comb begin
        retire           = '0;
        retire.next_pc   = result.next_pc;
        retire.rd        = result.rd;
        retire.writes_rd = result.writes_rd;
        case (state)
            S_IDLE:       retire.valid = result_valid && !result.is_load && !result.is_store;
            S_WRITE_RESP: retire.valid = bus_rsp.bvalid;
            S_READ_DATA:  retire.valid = bus_rsp.rvalid;
            default:      retire.valid = 1'b0;
        endcase

        if (result.is_load) begin
            retire.rd_value = bus_rsp.rdata;
        end else if (result.is_jump) begin
            retire.rd_value = result.link_value;
        end else begin
            retire.rd_value = result.alu_result;
        end
    end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_pkg::decoded_t     decoded,
    input  logic                 decoded_valid,
    output rv_pkg::exec_result_t result,
    output logic                 result_valid
);

    rv_pkg::word_t                op_a;
    rv_pkg::word_t                op_b;
    rv_pkg::word_t                alu_out;
    rv_pkg::word_t                link_value;
    rv_pkg::word_t                next_pc;
    logic [$clog2(`RV_XLEN)-1:0] shamt;

    assign op_a  = decoded.rs1_value;
    assign op_b  = decoded.use_imm ? decoded.imm : decoded.rs2_value;
    assign shamt = op_b[$clog2(`RV_XLEN)-1:0];

    always_comb begin
        case (decoded.alu_op)
            rv_pkg::ADD:    alu_out = op_a + op_b;
            rv_pkg::SUB:    alu_out = op_a - op_b;
            rv_pkg::SLT:    alu_out = ($signed(op_a) < $signed(op_b)) ? 1 : 0;
            rv_pkg::XOR:    alu_out = op_a ^ op_b;
            rv_pkg::OR:     alu_out = op_a | op_b;
            rv_pkg::AND:    alu_out = op_a & op_b;
            rv_pkg::SLL:    alu_out = op_a << shamt;
            rv_pkg::SRL:    alu_out = op_a >> shamt;
            rv_pkg::SRA:    alu_out = rv_pkg::word_t'($signed(op_a) >>> shamt);
            rv_pkg::PASS_B: alu_out = op_b;
            default:        alu_out = '0;
        endcase
    end

    assign link_value = decoded.pc + `RV_INSN_BYTES;

    // jalr target comes from the alu add, low bit cleared
    always_comb begin
        if (decoded.is_jal) begin
            next_pc = decoded.pc + decoded.imm;
        end else if (decoded.is_jalr) begin
            next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};
        end else begin
            next_pc = link_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= decoded_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (decoded_valid) begin
            result.alu_result <= alu_out;
            result.store_data <= decoded.rs2_value;
            result.link_value <= link_value;
            result.next_pc    <= next_pc;
            result.rd         <= decoded.rd;
            result.is_load    <= decoded.is_load;
            result.is_store   <= decoded.is_store;
            result.is_jump    <= decoded.is_jal | decoded.is_jalr;
            result.writes_rd  <= decoded.writes_rd;
        end
    end

endmodule

// ==== src/rv_fetch_decode.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_fetch_decode (
    input  logic              clk,
    input  logic              rst,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_value,
    input  rv_pkg::word_t     rs2_value,
    input  rv_pkg::retire_t   retire,
    output rv_pkg::decoded_t  decoded,
    output logic              decoded_valid
);

    rv_pkg::word_t    pc;
    logic             fetch_pending;
    rv_pkg::opcode_t  opcode;
    logic [2:0]       funct3;
    rv_pkg::decoded_t dec;

    assign imem_addr = pc;
    assign funct3    = imem_data[14:12];
    assign rs1_addr  = imem_data[19:15];
    assign rs2_addr  = imem_data[24:20];

    always_comb begin
        case (imem_data[6:0])
            rv_pkg::OP, rv_pkg::OP_IMM, rv_pkg::LUI, rv_pkg::LOAD,
            rv_pkg::STORE, rv_pkg::JAL, rv_pkg::JALR: begin
                opcode = rv_pkg::opcode_t'(imem_data[6:0]);
            end
            default: opcode = rv_pkg::ILLEGAL;
        endcase
    end

    always_comb begin
        dec           = '0;
        dec.pc        = pc;
        dec.rs1_value = rs1_value;
        dec.rs2_value = rs2_value;
        dec.rd        = imem_data[11:7];
        dec.alu_op    = rv_pkg::ADD;
        // I-type immediate unless the format says otherwise
        dec.imm       = {{20{imem_data[31]}}, imem_data[31:20]};

        case (opcode)
            rv_pkg::OP, rv_pkg::OP_IMM: begin
                dec.use_imm   = (opcode == rv_pkg::OP_IMM);
                dec.writes_rd = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (opcode == rv_pkg::OP && imem_data[30]) begin
                            dec.alu_op = rv_pkg::SUB;
                        end
                    end
                    3'b010: begin
                        dec.alu_op    = rv_pkg::SLT;
                        dec.writes_rd = (opcode == rv_pkg::OP);
                    end
                    3'b100: dec.alu_op = rv_pkg::XOR;
                    3'b110: dec.alu_op = rv_pkg::OR;
                    3'b111: dec.alu_op = rv_pkg::AND;
                    3'b001: begin
                        dec.alu_op    = rv_pkg::SLL;
                        dec.writes_rd = (opcode == rv_pkg::OP_IMM);
                    end
                    3'b101: begin
                        dec.alu_op    = imem_data[30] ? rv_pkg::SRA : rv_pkg::SRL;
                        dec.writes_rd = (opcode == rv_pkg::OP_IMM);
                    end
                    // sltu and friends retire as no-ops
                    default: dec.writes_rd = 1'b0;
                endcase
            end
            rv_pkg::LUI: begin
                dec.imm       = {imem_data[31:12], 12'b0};
                dec.alu_op    = rv_pkg::PASS_B;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::LOAD: begin
                dec.use_imm   = 1'b1;
                dec.is_load   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::STORE: begin
                dec.imm      = {{20{imem_data[31]}}, imem_data[31:25], imem_data[11:7]};
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            rv_pkg::JAL: begin
                dec.imm = {{12{imem_data[31]}}, imem_data[19:12], imem_data[20],
                           imem_data[30:21], 1'b0};
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::JALR: begin
                dec.use_imm   = 1'b1;
                dec.is_jalr   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            // illegal only moves the pc on
            default: dec.writes_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc            <= `RV_RESET_PC;
            fetch_pending <= 1'b1;
            decoded_valid <= 1'b0;
        end else begin
            decoded_valid <= fetch_pending;
            if (fetch_pending) begin
                fetch_pending <= 1'b0;
            end
            if (retire.valid) begin
                pc            <= retire.next_pc;
                fetch_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_pending) begin
            decoded <= dec;
        end
    end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_value,
    output rv_pkg::word_t     rs2_value,
    input  rv_pkg::retire_t   retire
);

    rv_pkg::word_t regs [`RV_REG_COUNT];

    assign rs1_value = regs[rs1_addr];
    assign rs2_value = regs[rs2_addr];

    // x0 is never written, so it reads zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.writes_rd && retire.rd != '0) begin
            regs[retire.rd] <= retire.rd_value;
        end
    end

endmodule

// ==== src/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OP      = 7'b0110011,
        OP_IMM  = 7'b0010011,
        LUI     = 7'b0110111,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        ILLEGAL = 7'b0000000
    } opcode_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        PASS_B
    } alu_op_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_value;
        word_t     rs2_value;
        word_t     imm;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_jal;
        logic      is_jalr;
        logic      writes_rd;
    } decoded_t;

    // alu_result doubles as the load/store address
    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        word_t     link_value;
        word_t     next_pc;
        reg_addr_t rd;
        logic      is_load;
        logic      is_store;
        logic      is_jump;
        logic      writes_rd;
    } exec_result_t;

    typedef struct packed {
        logic      valid;
        word_t     next_pc;
        reg_addr_t rd;
        word_t     rd_value;
        logic      writes_rd;
    } retire_t;

    // axi4-lite master side
    typedef struct packed {
        logic                   awvalid;
        word_t                  awaddr;
        logic                   wvalid;
        word_t                  wdata;
        logic [`RV_XLEN/8-1:0] wstrb;
        logic                   bready;
        logic                   arvalid;
        word_t                  araddr;
        logic                   rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        word_t      rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage

// ==== src/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// pc step per instruction
`define RV_INSN_BYTES 4

`endif
